/* verilog.f */
cache_pkg.sv
cache_tag_array.sv
cache_data_array.sv
cache_fill_ctrl.sv
cache_unit.sv
mem_arbiter.sv
cache_controller.sv
tb_cache_checker.sv
tb_cache_controller.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cache_controller
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_cache_controller.sv */
module tb_cache_controller;
    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [cache_pkg::ADDR_W-1:0] addr_t;
    typedef logic [cache_pkg::DATA_W-1:0] word_t;

    localparam int NUM_BLOCKS = 128;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int SEED = 91863;

    logic  clk;
    logic  rst;
    addr_t instr_addr;
    logic  instr_rd_en;
    word_t instr_data;
    logic  instr_stall;
    addr_t data_addr;
    logic  data_rd_en;
    word_t data_data;
    logic  data_stall;
    logic  mem_req;
    addr_t mem_addr;
    logic  mem_ack = 1'b0;
    word_t mem_rdata = '0;
    logic  test_end;
    int    test_id;
    int    exp_reqs;
    int    err_count;
    int    check_count;
    int    tests_run = 0;
    int    stim_seed = SEED;
    int    rsp_seed = SEED;
    int    rsp_phase = 0;    // 0 idle, 1 ack delay, 2 ack held
    int    rsp_wait = 0;

    function automatic word_t mem_word(input addr_t addr);
        return {addr[cache_pkg::ADDR_W-6:0], addr[cache_pkg::ADDR_W-1 -: 5]} ^ 16'h3C96;
    endfunction

    // Small window with a tag bit so lines conflict
    function automatic addr_t rand_addr();
        int r;
        r = $random(stim_seed);
        return addr_t'(32'h6000 | (r & 32'h043F));
    endfunction

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic read_instr(input addr_t addr);
        int waited;
        instr_addr  <= addr;
        instr_rd_en <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (instr_stall && waited < TIMEOUT_CYCLES);
        if (instr_stall) begin
            abort_run($sformatf("instruction port still stalled at address %h", addr));
        end
    endtask

    task automatic read_data(input addr_t addr);
        int waited;
        data_addr  <= addr;
        data_rd_en <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (data_stall && waited < TIMEOUT_CYCLES);
        if (data_stall) begin
            abort_run($sformatf("data port still stalled at address %h", addr));
        end
    endtask

    task automatic read_both(input addr_t iaddr, input addr_t daddr);
        int waited;
        instr_addr  <= iaddr;
        instr_rd_en <= 1'b1;
        data_addr   <= daddr;
        data_rd_en  <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while ((instr_stall || data_stall) && waited < TIMEOUT_CYCLES);
        if (instr_stall || data_stall) begin
            abort_run($sformatf("%s still stalled on a concurrent read",
                                instr_stall ? "instruction port" : "data port"));
        end
    endtask

    task automatic end_test(input int id, input int reqs);
        instr_rd_en <= 1'b0;
        data_rd_en  <= 1'b0;
        @(posedge clk);
        test_id  <= id;
        exp_reqs <= reqs;
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
        tests_run++;
        @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Main memory side of the four-phase handshake
    always @(posedge clk) begin
        if (rst) begin
            mem_ack   <= 1'b0;
            rsp_phase <= 0;
        end else begin
            case (rsp_phase)
                0: begin
                    if (mem_req) begin
                        rsp_wait  <= $random(rsp_seed) & 3;
                        rsp_phase <= 1;
                    end
                end
                1: begin
                    if (rsp_wait == 0) begin
                        mem_ack   <= 1'b1;
                        mem_rdata <= mem_word(mem_addr);
                        rsp_phase <= 2;
                    end else begin
                        rsp_wait <= rsp_wait - 1;
                    end
                end
                default: begin
                    if (!mem_req) begin
                        mem_ack   <= 1'b0;
                        rsp_phase <= 0;
                    end
                end
            endcase
        end
    end

    cache_controller #(.NUM_BLOCKS(NUM_BLOCKS)) u_cache_controller (
        .clk           (clk),
        .i_rst         (rst),
        .i_instr_addr  (instr_addr),
        .i_instr_rd_en (instr_rd_en),
        .o_instr_data  (instr_data),
        .o_instr_stall (instr_stall),
        .i_data_addr   (data_addr),
        .i_data_rd_en  (data_rd_en),
        .o_data_data   (data_data),
        .o_data_stall  (data_stall),
        .o_mem_req     (mem_req),
        .o_mem_addr    (mem_addr),
        .i_mem_ack     (mem_ack),
        .i_mem_rdata   (mem_rdata)
    );

    tb_cache_checker #(.NUM_BLOCKS(NUM_BLOCKS)) u_checker (
        .clk           (clk),
        .i_rst         (rst),
        .i_instr_addr  (instr_addr),
        .i_instr_rd_en (instr_rd_en),
        .i_instr_data  (instr_data),
        .i_instr_stall (instr_stall),
        .i_data_addr   (data_addr),
        .i_data_rd_en  (data_rd_en),
        .i_data_data   (data_data),
        .i_data_stall  (data_stall),
        .i_mem_req     (mem_req),
        .i_test_end    (test_end),
        .i_test_id     (test_id),
        .i_exp_reqs    (exp_reqs),
        .o_err_count   (err_count),
        .o_check_count (check_count)
    );

    initial begin
        rst         = 1'b1;
        instr_addr  = '0;
        instr_rd_en = 1'b0;
        data_addr   = '0;
        data_rd_en  = 1'b0;
        test_end    = 1'b0;
        test_id     = 0;
        exp_reqs    = -1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        read_instr(16'h0103);
        for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
            read_instr(addr_t'(32'h0100 + w));
        end
        end_test(1, 8);

        read_data(16'h0245);
        for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
            read_data(addr_t'(32'h0240 + w));
        end
        end_test(2, 8);

        read_both(16'h0388, 16'h04C8);    // Different lines in the same cycle
        read_both(16'h038F, 16'h04CB);
        end_test(3, 16);

        read_instr(16'h1A50);
        read_instr(16'h2A50);    // Same index with another tag
        read_instr(16'h1A50);
        read_instr(16'h1A55);
        end_test(4, 24);

        for (int n = 0; n < 100; n++) begin
            read_both(rand_addr(), rand_addr());
        end
        end_test(5, -1);

        read_instr(16'h0102);
        instr_rd_en <= 1'b0;
        @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        read_instr(16'h0102);
        end_test(6, 8);

        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, err_count);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* tb_cache_checker.sv */
module tb_cache_checker #(
    parameter int NUM_BLOCKS = 128
) (
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic [cache_pkg::ADDR_W-1:0] i_instr_addr,
    input  logic                         i_instr_rd_en,
    input  logic [cache_pkg::DATA_W-1:0] i_instr_data,
    input  logic                         i_instr_stall,
    input  logic [cache_pkg::ADDR_W-1:0] i_data_addr,
    input  logic                         i_data_rd_en,
    input  logic [cache_pkg::DATA_W-1:0] i_data_data,
    input  logic                         i_data_stall,
    input  logic                         i_mem_req,
    input  logic                         i_test_end,
    input  int                           i_test_id,
    input  int                           i_exp_reqs,
    output int                           o_err_count,
    output int                           o_check_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int OFF_W = cache_pkg::WORD_OFF_W;
    localparam int INDEX_W = $clog2(NUM_BLOCKS);
    localparam int LINE_W = cache_pkg::ADDR_W - OFF_W;

    logic [LINE_W-1:0]     iline [NUM_BLOCKS];    // Shadow tags hold the whole line address
    logic [LINE_W-1:0]     dline [NUM_BLOCKS];
    logic [NUM_BLOCKS-1:0] ivalid;
    logic [NUM_BLOCKS-1:0] dvalid;
    logic [INDEX_W-1:0]    iidx;
    logic [INDEX_W-1:0]    didx;
    logic                  req_q;
    logic                  rst_q;
    int req_count = 0;
    int miss_count = 0;
    int err_count = 0;
    int check_count = 0;
    int req_base = 0;
    int miss_base = 0;
    int err_base = 0;
    int reqs;
    int misses;

    // Main memory contents, A rotated left by 5 then XOR 0x3C96
    function automatic logic [cache_pkg::DATA_W-1:0] expected_word(
        input logic [cache_pkg::ADDR_W-1:0] addr
    );
        return {addr[cache_pkg::ADDR_W-6:0], addr[cache_pkg::ADDR_W-1 -: 5]} ^ 16'h3C96;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "cold instruction miss";
            2: return "cold data miss";
            3: return "concurrent misses";
            4: return "conflict eviction";
            5: return "random traffic";
            6: return "reset";
            default: return "unnamed";
        endcase
    endfunction

    task automatic check_word(
        input string                        name,
        input logic [cache_pkg::ADDR_W-1:0] addr,
        input logic [cache_pkg::DATA_W-1:0] got
    );
        logic [cache_pkg::DATA_W-1:0] exp;
        exp = expected_word(addr);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("MISMATCH %s at %h: expected %h got %h", name, addr, exp, got);
        end
    endtask

    always @(posedge clk) begin
        rst_q <= i_rst;
        req_q <= i_mem_req;
        if (i_mem_req && !req_q) begin
            req_count++;
        end
        iidx = i_instr_addr[OFF_W +: INDEX_W];
        didx = i_data_addr[OFF_W +: INDEX_W];
        if (i_rst) begin
            ivalid <= '0;
            dvalid <= '0;
        end else begin
            if (rst_q) begin    // First cycle out of reset
                check_count++;
                if (i_mem_req || (!i_instr_rd_en && i_instr_stall)
                        || (!i_data_rd_en && i_data_stall)) begin
                    err_count++;
                    $display("after reset the memory request or an idle stall output is high");
                end
            end
            if (i_instr_rd_en && !i_instr_stall) begin
                check_word("o_instr_data", i_instr_addr, i_instr_data);
                if (!(ivalid[iidx] && iline[iidx] == i_instr_addr[cache_pkg::ADDR_W-1:OFF_W])) begin
                    miss_count++;
                    ivalid[iidx] <= 1'b1;
                    iline[iidx]  <= i_instr_addr[cache_pkg::ADDR_W-1:OFF_W];
                end
            end
            if (i_data_rd_en && !i_data_stall) begin
                check_word("o_data_data", i_data_addr, i_data_data);
                if (!(dvalid[didx] && dline[didx] == i_data_addr[cache_pkg::ADDR_W-1:OFF_W])) begin
                    miss_count++;
                    dvalid[didx] <= 1'b1;
                    dline[didx]  <= i_data_addr[cache_pkg::ADDR_W-1:OFF_W];
                end
            end
            if (i_test_end) begin
                reqs   = req_count - req_base;
                misses = miss_count - miss_base;
                if (reqs != cache_pkg::WORDS_PER_LINE * misses) begin
                    err_count++;
                    $display("MISMATCH o_mem_req rising edges: expected %h got %h",
                             cache_pkg::WORDS_PER_LINE * misses, reqs);
                end
                if (i_exp_reqs >= 0 && reqs != i_exp_reqs) begin
                    err_count++;
                    $display("MISMATCH o_mem_req rising edges: expected %h got %h",
                             i_exp_reqs, reqs);
                end
                $display("test %0d %s: %0d memory requests, %0d misses, %0d errors",
                         i_test_id, test_name(i_test_id), reqs, misses, err_count - err_base);
                req_base  = req_count;
                miss_base = miss_count;
                err_base  = err_count;
            end
        end
    end

    assign o_err_count   = err_count;
    assign o_check_count = check_count;

endmodule

/* cache_controller.sv */
module cache_controller #(
    parameter int NUM_BLOCKS = 128
) (
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic [cache_pkg::ADDR_W-1:0] i_instr_addr,
    input  logic                         i_instr_rd_en,
    output logic [cache_pkg::DATA_W-1:0] o_instr_data,
    output logic                         o_instr_stall,
    input  logic [cache_pkg::ADDR_W-1:0] i_data_addr,
    input  logic                         i_data_rd_en,
    output logic [cache_pkg::DATA_W-1:0] o_data_data,
    output logic                         o_data_stall,
    output logic                         o_mem_req,
    output logic [cache_pkg::ADDR_W-1:0] o_mem_addr,
    input  logic                         i_mem_ack,
    input  logic [cache_pkg::DATA_W-1:0] i_mem_rdata
);

    logic                         icache_req;
    logic [cache_pkg::ADDR_W-1:0] icache_addr;
    logic                         icache_ack;
    logic [cache_pkg::DATA_W-1:0] icache_rdata;
    logic                         dcache_req;
    logic [cache_pkg::ADDR_W-1:0] dcache_addr;
    logic                         dcache_ack;
    logic [cache_pkg::DATA_W-1:0] dcache_rdata;

    cache_unit #(.NUM_BLOCKS(NUM_BLOCKS)) u_icache (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_addr      (i_instr_addr),
        .i_rd_en     (i_instr_rd_en),
        .o_rdata     (o_instr_data),
        .o_stall     (o_instr_stall),
        .o_mem_req   (icache_req),
        .o_mem_addr  (icache_addr),
        .i_mem_ack   (icache_ack),
        .i_mem_rdata (icache_rdata)
    );

    cache_unit #(.NUM_BLOCKS(NUM_BLOCKS)) u_dcache (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_addr      (i_data_addr),
        .i_rd_en     (i_data_rd_en),
        .o_rdata     (o_data_data),
        .o_stall     (o_data_stall),
        .o_mem_req   (dcache_req),
        .o_mem_addr  (dcache_addr),
        .i_mem_ack   (dcache_ack),
        .i_mem_rdata (dcache_rdata)
    );

    mem_arbiter u_mem_arbiter (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_instr_req   (icache_req),
        .i_instr_addr  (icache_addr),
        .o_instr_ack   (icache_ack),
        .o_instr_rdata (icache_rdata),
        .i_data_req    (dcache_req),
        .i_data_addr   (dcache_addr),
        .o_data_ack    (dcache_ack),
        .o_data_rdata  (dcache_rdata),
        .o_mem_req     (o_mem_req),
        .o_mem_addr    (o_mem_addr),
        .i_mem_ack     (i_mem_ack),
        .i_mem_rdata   (i_mem_rdata)
    );

endmodule

/* mem_arbiter.sv */
module mem_arbiter (
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic                         i_instr_req,
    input  logic [cache_pkg::ADDR_W-1:0] i_instr_addr,
    output logic                         o_instr_ack,
    output logic [cache_pkg::DATA_W-1:0] o_instr_rdata,
    input  logic                         i_data_req,
    input  logic [cache_pkg::ADDR_W-1:0] i_data_addr,
    output logic                         o_data_ack,
    output logic [cache_pkg::DATA_W-1:0] o_data_rdata,
    output logic                         o_mem_req,
    output logic [cache_pkg::ADDR_W-1:0] o_mem_addr,
    input  logic                         i_mem_ack,
    input  logic [cache_pkg::DATA_W-1:0] i_mem_rdata
);

    cache_pkg::arb_state_e owner;
    logic                  owner_req;
    logic                  instr_own;
    logic                  data_own;

    assign instr_own = (owner == cache_pkg::ARB_INSTR);
    assign data_own  = (owner == cache_pkg::ARB_DATA);
    assign owner_req = (instr_own && i_instr_req) || (data_own && i_data_req);

    // Grant lasts one four-phase transfer
    always_ff @(posedge clk) begin
        if (i_rst) begin
            owner <= cache_pkg::ARB_IDLE;
        end else begin
            case (owner)
                cache_pkg::ARB_IDLE: begin
                    if (i_instr_req) begin
                        owner <= cache_pkg::ARB_INSTR;    // Instruction side first
                    end else if (i_data_req) begin
                        owner <= cache_pkg::ARB_DATA;
                    end
                end
                default: begin
                    if (!owner_req && !i_mem_ack) begin
                        owner <= cache_pkg::ARB_IDLE;
                    end
                end
            endcase
        end
    end

    assign o_mem_req  = owner_req;
    assign o_mem_addr = data_own ? i_data_addr : i_instr_addr;

    assign o_instr_ack   = instr_own && i_mem_ack;
    assign o_instr_rdata = instr_own ? i_mem_rdata : '0;
    assign o_data_ack    = data_own && i_mem_ack;
    assign o_data_rdata  = data_own ? i_mem_rdata : '0;

    // Both fill controllers must never see the same ack
    a_one_ack: assert property (
        @(posedge clk) disable iff (i_rst)
        !(o_instr_ack && o_data_ack)
    ) else $error("memory ack steered to both caches");

endmodule

/* cache_unit.sv */
module cache_unit #(
    parameter int NUM_BLOCKS = 128
) (
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic [cache_pkg::ADDR_W-1:0] i_addr,
    input  logic                         i_rd_en,
    output logic [cache_pkg::DATA_W-1:0] o_rdata,
    output logic                         o_stall,
    output logic                         o_mem_req,
    output logic [cache_pkg::ADDR_W-1:0] o_mem_addr,
    input  logic                         i_mem_ack,
    input  logic [cache_pkg::DATA_W-1:0] i_mem_rdata
);

    logic                         hit;
    logic                         busy;
    logic                         miss;
    logic                         arr_we;
    logic                         tag_we;
    logic [cache_pkg::ADDR_W-1:0] arr_addr;
    logic [cache_pkg::DATA_W-1:0] arr_wdata;

    assign miss = i_rd_en && !hit && !busy;
    // Busy covers a line that is only partly written
    assign o_stall = i_rd_en && (!hit || busy);

    cache_tag_array #(.NUM_BLOCKS(NUM_BLOCKS)) u_tag_array (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_lookup_addr (i_addr),
        .i_fill_addr   (arr_addr),
        .i_tag_we      (tag_we),
        .o_hit         (hit)
    );

    cache_data_array #(.NUM_BLOCKS(NUM_BLOCKS)) u_data_array (
        .clk       (clk),
        .i_rd_addr (i_addr),
        .i_wr_addr (arr_addr),
        .i_we      (arr_we),
        .i_wdata   (arr_wdata),
        .o_rdata   (o_rdata)
    );

    cache_fill_ctrl #(.NUM_BLOCKS(NUM_BLOCKS)) u_fill_ctrl (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_miss      (miss),
        .i_miss_addr (i_addr),
        .o_busy      (busy),
        .o_mem_req   (o_mem_req),
        .o_mem_addr  (o_mem_addr),
        .i_mem_ack   (i_mem_ack),
        .i_mem_rdata (i_mem_rdata),
        .o_arr_we    (arr_we),
        .o_arr_addr  (arr_addr),
        .o_arr_wdata (arr_wdata),
        .o_tag_we    (tag_we)
    );

endmodule

/* cache_fill_ctrl.sv */
module cache_fill_ctrl #(
    parameter int NUM_BLOCKS = 128
) (
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic                         i_miss,
    input  logic [cache_pkg::ADDR_W-1:0] i_miss_addr,
    output logic                         o_busy,
    output logic                         o_mem_req,
    output logic [cache_pkg::ADDR_W-1:0] o_mem_addr,
    input  logic                         i_mem_ack,
    input  logic [cache_pkg::DATA_W-1:0] i_mem_rdata,
    output logic                         o_arr_we,
    output logic [cache_pkg::ADDR_W-1:0] o_arr_addr,
    output logic [cache_pkg::DATA_W-1:0] o_arr_wdata,
    output logic                         o_tag_we
);

    localparam int OFF_W = cache_pkg::WORD_OFF_W;
    localparam int INDEX_W = $clog2(NUM_BLOCKS);
    localparam int TAG_W = cache_pkg::ADDR_W - INDEX_W - OFF_W;
    localparam logic [OFF_W-1:0] LAST_WORD = OFF_W'(cache_pkg::WORDS_PER_LINE - 1);

    cache_pkg::fill_state_e       state;
    cache_pkg::fill_state_e       state_next;
    logic [TAG_W-1:0]             fill_tag;
    logic [INDEX_W-1:0]           fill_idx;
    logic [OFF_W-1:0]             word_cnt;    // Words fetched from memory
    logic [OFF_W-1:0]             wr_cnt;      // Words written to the array
    logic [cache_pkg::DATA_W-1:0] line_buf [cache_pkg::WORDS_PER_LINE];
    logic                         start;

    assign start = (state == cache_pkg::FILL_IDLE) && i_miss;

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::FILL_IDLE: begin
                if (i_miss) begin
                    state_next = cache_pkg::FILL_REQ;
                end
            end
            cache_pkg::FILL_REQ: begin
                state_next = cache_pkg::FILL_WAIT_ACK;
            end
            cache_pkg::FILL_WAIT_ACK: begin
                if (i_mem_ack) begin
                    state_next = cache_pkg::FILL_WAIT_RELEASE;
                end
            end
            cache_pkg::FILL_WAIT_RELEASE: begin
                if (!i_mem_ack) begin
                    state_next = (word_cnt == LAST_WORD) ? cache_pkg::FILL_WRITE
                                                         : cache_pkg::FILL_REQ;
                end
            end
            cache_pkg::FILL_WRITE: begin
                if (wr_cnt == LAST_WORD) begin
                    state_next = cache_pkg::FILL_IDLE;
                end
            end
            default: state_next = cache_pkg::FILL_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state    <= cache_pkg::FILL_IDLE;
            word_cnt <= '0;
            wr_cnt   <= '0;
        end else begin
            state <= state_next;
            if (start) begin
                word_cnt <= '0;
                wr_cnt   <= '0;
            end else if (state == cache_pkg::FILL_WAIT_RELEASE && !i_mem_ack) begin
                word_cnt <= word_cnt + 1'b1;
            end else if (state == cache_pkg::FILL_WRITE) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            fill_tag <= i_miss_addr[cache_pkg::ADDR_W-1 -: TAG_W];
            fill_idx <= i_miss_addr[OFF_W +: INDEX_W];
        end
        if (state == cache_pkg::FILL_WAIT_ACK && i_mem_ack) begin
            line_buf[word_cnt] <= i_mem_rdata;    // Capture on ack, req drops next
        end
    end

    assign o_busy      = (state != cache_pkg::FILL_IDLE);
    assign o_mem_req   = (state == cache_pkg::FILL_REQ) || (state == cache_pkg::FILL_WAIT_ACK);
    assign o_mem_addr  = {fill_tag, fill_idx, word_cnt};
    assign o_arr_we    = (state == cache_pkg::FILL_WRITE);
    assign o_arr_addr  = {fill_tag, fill_idx, wr_cnt};
    assign o_arr_wdata = line_buf[wr_cnt];
    assign o_tag_we    = o_arr_we && (wr_cnt == LAST_WORD);    // Tag goes in with the last word

    // Request must not be withdrawn or move before the responder acks
    a_req_held: assert property (
        @(posedge clk) disable iff (i_rst)
        (o_mem_req && !i_mem_ack) |=>
            (state == cache_pkg::FILL_WAIT_ACK) && o_mem_req && $stable(o_mem_addr)
    ) else $error("fill request dropped or moved before ack");

endmodule

/* cache_data_array.sv */
module cache_data_array #(
    parameter int NUM_BLOCKS = 128
) (
    input  logic                         clk,
    input  logic [cache_pkg::ADDR_W-1:0] i_rd_addr,
    input  logic [cache_pkg::ADDR_W-1:0] i_wr_addr,
    input  logic                         i_we,
    input  logic [cache_pkg::DATA_W-1:0] i_wdata,
    output logic [cache_pkg::DATA_W-1:0] o_rdata
);

    localparam int INDEX_W = $clog2(NUM_BLOCKS);
    localparam int WORD_AW = INDEX_W + cache_pkg::WORD_OFF_W;    // Index and offset together
    localparam int DEPTH = NUM_BLOCKS * cache_pkg::WORDS_PER_LINE;

    logic [cache_pkg::DATA_W-1:0] mem [DEPTH];
    logic [WORD_AW-1:0]           rd_word;
    logic [WORD_AW-1:0]           wr_word;

    assign rd_word = i_rd_addr[WORD_AW-1:0];
    assign wr_word = i_wr_addr[WORD_AW-1:0];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[wr_word] <= i_wdata;
        end
    end

    assign o_rdata = mem[rd_word];    // Same-cycle read for hits

endmodule

/* cache_tag_array.sv */
module cache_tag_array #(
    parameter int NUM_BLOCKS = 128
) (
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic [cache_pkg::ADDR_W-1:0] i_lookup_addr,
    input  logic [cache_pkg::ADDR_W-1:0] i_fill_addr,
    input  logic                         i_tag_we,
    output logic                         o_hit
);

    localparam int OFF_W = cache_pkg::WORD_OFF_W;
    localparam int INDEX_W = $clog2(NUM_BLOCKS);
    localparam int TAG_W = cache_pkg::ADDR_W - INDEX_W - OFF_W;

    logic [TAG_W-1:0]      tag_mem [NUM_BLOCKS];
    logic [NUM_BLOCKS-1:0] valid;
    logic [INDEX_W-1:0]    lookup_idx;
    logic [INDEX_W-1:0]    fill_idx;
    logic [TAG_W-1:0]      lookup_tag;
    logic [TAG_W-1:0]      fill_tag;

    assign lookup_idx = i_lookup_addr[OFF_W +: INDEX_W];
    assign lookup_tag = i_lookup_addr[cache_pkg::ADDR_W-1 -: TAG_W];
    assign fill_idx   = i_fill_addr[OFF_W +: INDEX_W];
    assign fill_tag   = i_fill_addr[cache_pkg::ADDR_W-1 -: TAG_W];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            valid <= '0;
        end else if (i_tag_we) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_tag_we) begin
            tag_mem[fill_idx] <= fill_tag;
        end
    end

    assign o_hit = valid[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);

endmodule

/* cache_pkg.sv */
package cache_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 16;
    localparam int WORD_OFF_W = 3;    // Word select within a line
    localparam int WORDS_PER_LINE = 8;

    // Miss handling sequence, one four-phase transfer per word
    typedef enum logic [2:0] {
        FILL_IDLE,
        FILL_REQ,
        FILL_WAIT_ACK,
        FILL_WAIT_RELEASE,
        FILL_WRITE
    } fill_state_e;

    // Current owner of the memory port
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_INSTR,
        ARB_DATA
    } arb_state_e;

endpackage
